// File: Bender.yml
package:
  name: rv32i_core

sources:
  # packages first, the control package imports the isa package
  - verilog/core_isa_pkg.sv
  - verilog/core_ctrl_pkg.sv
  # core rtl, leaf modules before the top level
  - verilog/core_decoder.sv
  - verilog/core_alu.sv
  - verilog/core_reg_file.sv
  - verilog/core_top.sv
  # testbench
  - target: test
    files:
      - tests/tb_core.sv

// File: files.f
verilog/core_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/core_decoder.sv
verilog/core_alu.sv
verilog/core_reg_file.sv
verilog/core_top.sv
tests/tb_core.sv

// File: tests/core_cases.mem
// from @00: program image, instruction words in fetch order
// from @80: store count, then expected stores as address data pairs in order
@00
ff800093 00c00113                              // x1 = -8, x2 = 12
002081b3 40208233 002092b3 0020a333 0020b3b3   // add sub sll slt sltu
0020c433 0020d4b3 4020d533 0020e5b3 0020f633   // xor srl sra or and
4020d693 0f00f713 123457b7 00001817            // srai andi lui, auipc at 0x3c
10102023 10302223 10402423 10502623 10602823   // results to 0x100 upward
10702a23 10802c23 10902e23 12a02023 12b02223
12c02423 12d02623 12e02823 12f02a23 13002c23
00a00893 00b00913                              // markers x17 = 0xa, x18 = 0xb
00210463 19102023 19202223 00208463 19102023 19202223   // beq taken, not taken
00209463 19102023 19202223 00211463 19102023 19202223   // bne
0020c463 19102023 19202223 00114463 19102023 19202223   // blt
00115463 19102023 19202223 0020d463 19102023 19202223   // bge
00116463 19102023 19202223 0020e463 19102023 19202223   // bltu
0020f463 19102023 19202223 00117463 19102023 19202223   // bgeu
008009ef 19102023 19302423                     // jal x19 at 0x114 over one store
00000a97 00da8a67 19102023 19402623            // auipc x21, jalr x20 to 0x12c
10002b03 001b0b13 19602823                     // lw 0x100, plus one, store
00710013 18002a23                              // write x0, store x0
ffffffff 19202c23 0000006f                     // unknown opcode, last store, spin
@80
00000026
00000100 fffffff8 00000104 00000004 00000108 ffffffec 0000010c ffff8000
00000110 00000001 00000114 00000000 00000118 fffffff4 0000011c 000fffff
00000120 ffffffff 00000124 fffffffc 00000128 00000008 0000012c fffffffe
00000130 000000f0 00000134 12345000 00000138 0000103c
00000184 0000000b 00000180 0000000a 00000184 0000000b   // beq
00000184 0000000b 00000180 0000000a 00000184 0000000b   // bne
00000184 0000000b 00000180 0000000a 00000184 0000000b   // blt
00000184 0000000b 00000180 0000000a 00000184 0000000b   // bge
00000184 0000000b 00000180 0000000a 00000184 0000000b   // bltu
00000184 0000000b 00000180 0000000a 00000184 0000000b   // bgeu
00000188 00000118 0000018c 00000128                     // jal and jalr links
00000190 fffffff9 00000194 00000000 00000198 0000000b   // load, x0, last store

// File: tests/tb_core.sv
module tb_core;
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int mem_words      = 256;
    localparam int exp_base       = 'h80;   // first word after the program image
    localparam int timeout_cycles = 2000;
    localparam int reset_cycles   = 4;
    localparam int drive_delay    = 2;

    localparam word_t reset_instr = 32'h0000_2023;   // store word fed during reset

    logic      CLK;
    logic      RESET;
    word_t     pc;
    word_t     instr;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t cases_mem [0:mem_words-1];   // program, then count and address/data pairs
    word_t data_mem  [0:mem_words-1];
    int    store_count;
    int    stores_seen;
    int    cycles;

    core_top u_core_top (
        .CLK          (CLK),
        .RESET        (RESET),
        .pc_o         (pc),
        .instr_i      (instr),
        .dmem_o       (dmem_req),
        .dmem_rdata_i (dmem_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // memory models
    //////////////////////////////////////////////////////////////////////
    // store during reset and nop outside the image
    assign instr      = RESET ? reset_instr :
                        (pc < exp_base * 4) ? cases_mem[pc[9:2]] : nop_instr;
    assign dmem_rdata = data_mem[dmem_req.addr[9:2]];   // word addressed, aliases above 1k

    always @(posedge CLK) begin
        if (!RESET && dmem_req.req && dmem_req.we) begin
            data_mem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // failure helpers
    //////////////////////////////////////////////////////////////////////
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL at %0t: %s is %08h, expected %08h",
                                        $time, what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // store monitor, sampled mid cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge CLK) begin
        if (!RESET && dmem_req.req && dmem_req.we) begin
            if (stores_seen >= store_count) begin
                stop_with_failure($sformatf(
                    "the core wrote %08h to %08h after all expected stores were seen",
                    dmem_req.wdata, dmem_req.addr));
            end else begin
                check_value($sformatf("store %0d address", stores_seen), dmem_req.addr,
                            cases_mem[exp_base + 1 + 2 * stores_seen]);
                check_value($sformatf("store %0d data", stores_seen), dmem_req.wdata,
                            cases_mem[exp_base + 2 + 2 * stores_seen]);
                stores_seen++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        RESET       = 1'b1;
        stores_seen = 0;
        store_count = 0;
        cycles      = 0;
        $readmemh("tests/core_cases.mem", cases_mem);
        if ($isunknown(cases_mem[exp_base])) begin
            stop_with_failure("the cases file has no store count, it may be missing");
        end
        store_count = cases_mem[exp_base];

        // pc and data port idle in reset and the first cycle after it
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge CLK);
            #drive_delay;
            if (i == reset_cycles - 1) begin
                RESET = 1'b0;
            end
            @(negedge CLK);
            check_value("pc near reset", pc, 32'h0000_0000);
            check_value("dmem req near reset", {31'b0, dmem_req.req}, '0);
            check_value("dmem we near reset", {31'b0, dmem_req.we}, '0);
        end

        while (stores_seen < store_count && cycles < timeout_cycles) begin
            @(posedge CLK);
            cycles++;
        end

        if (stores_seen < store_count) begin
            stop_with_failure($sformatf(
                "the program did not finish, %0d of %0d stores seen in %0d cycles",
                stores_seen, store_count, cycles));
        end else begin
            repeat (16) @(posedge CLK);   // spin loop must stay quiet
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/core_alu.sv
module core_alu (
    input  core_isa_pkg::word_t    op_a_i,
    input  core_isa_pkg::word_t    op_b_i,
    input  core_ctrl_pkg::alu_op_t alu_op_i,
    output core_isa_pkg::word_t    result_o,
    output logic                   flag_o
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [$clog2(xlen)-1:0] shamt;
    logic                    lt_s;
    logic                    lt_u;

    assign shamt = op_b_i[$clog2(xlen)-1:0];   // low five bits only
    assign lt_s  = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u  = op_a_i < op_b_i;

    //////////////////////////////////////////////////////////////////////
    // result and branch flag
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        result_o = '0;   // stays zero for compares
        flag_o   = 1'b0;
        case (alu_op_i)
            alu_add:  result_o = op_a_i + op_b_i;
            alu_sub:  result_o = op_a_i - op_b_i;
            alu_sll:  result_o = op_a_i << shamt;
            alu_slt:  result_o = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: result_o = {{(xlen-1){1'b0}}, lt_u};
            alu_xor:  result_o = op_a_i ^ op_b_i;
            alu_srl:  result_o = op_a_i >> shamt;
            alu_sra:  result_o = word_t'($signed(op_a_i) >>> shamt);   // sign fill
            alu_or:   result_o = op_a_i | op_b_i;
            alu_and:  result_o = op_a_i & op_b_i;
            // branch conditions
            alu_eq:   flag_o = (op_a_i == op_b_i);
            alu_ne:   flag_o = (op_a_i != op_b_i);
            alu_lt:   flag_o = lt_s;
            alu_ge:   flag_o = !lt_s;
            alu_ltu:  flag_o = lt_u;
            alu_geu:  flag_o = !lt_u;
            default:  ;
        endcase
    end

endmodule

// File: verilog/core_ctrl_pkg.sv
package core_ctrl_pkg;
    import core_isa_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // datapath control encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt,
        alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and,
        alu_eq, alu_ne, alu_lt, alu_ge,   // compares drive the flag only
        alu_ltu, alu_geu
    } alu_op_t;

    typedef enum logic [1:0] {
        op_a_rs1,
        op_a_pc,
        op_a_zero   // lui
    } op_a_sel_t;

    typedef enum logic [2:0] {
        op_b_rs2,
        op_b_imm_i,
        op_b_imm_u,
        op_b_imm_s,
        op_b_four   // link value for jal / jalr
    } op_b_sel_t;

    typedef enum logic [1:0] {
        pc_sel_next,
        pc_sel_branch,
        pc_sel_jal,
        pc_sel_jalr
    } pc_sel_t;

    // full decode of one instruction
    typedef struct packed {
        alu_op_t   alu_op;
        op_a_sel_t op_a_sel;
        op_b_sel_t op_b_sel;
        pc_sel_t   pc_sel;
        logic      mem_req;
        logic      mem_we;
        logic      rf_we;
        logic      wb_from_mem;   // load data instead of alu result
    } ctrl_t;

    // one word access on the data port
    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    localparam word_t pc_step  = 32'd4;
    localparam word_t reset_pc = 32'd0;

endpackage

// File: verilog/core_decoder.sv
module core_decoder (
    input  core_isa_pkg::word_t  instr_i,
    output core_ctrl_pkg::ctrl_t ctrl_o,
    output core_isa_pkg::imm_t   imm_o
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t                instr_eff;   // unknown encodings replaced by nop
    opcode_t              opcode;
    logic [funct3_w-1:0]  funct3;
    logic [funct7_w-1:0]  funct7;
    reg_addr_t            rd;
    logic                 writes_rd;

    // checks opcode and funct fields against the supported subset
    function automatic logic is_legal(input word_t instr);
        logic [funct3_w-1:0] f3;
        logic [funct7_w-1:0] f7;
        f3 = instr[14:12];
        f7 = instr[31:25];
        case (opcode_t'(instr[opcode_w-1:0]))
            opc_op:     is_legal = (f7 == '0) ||
                                   (f7 == funct7_alt && (f3 == f3_add || f3 == f3_sr));
            opc_op_imm: is_legal = (f3 == f3_sll) ? (f7 == '0) :
                                   (f3 == f3_sr)  ? (f7 == '0 || f7 == funct7_alt) : 1'b1;
            opc_lui, opc_auipc, opc_jal: is_legal = 1'b1;
            opc_jalr:   is_legal = (f3 == '0);
            opc_branch: is_legal = f3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
            opc_load, opc_store: is_legal = (f3 == f3_word);   // words only
            default:    is_legal = 1'b0;
        endcase
    endfunction

    function automatic alu_op_t arith_op(input logic [funct3_w-1:0] f3, input logic alt);
        case (f3)
            f3_add:  arith_op = alt ? alu_sub : alu_add;
            f3_sll:  arith_op = alu_sll;
            f3_slt:  arith_op = alu_slt;
            f3_sltu: arith_op = alu_sltu;
            f3_xor:  arith_op = alu_xor;
            f3_sr:   arith_op = alt ? alu_sra : alu_srl;
            f3_or:   arith_op = alu_or;
            default: arith_op = alu_and;   // f3_and
        endcase
    endfunction

    function automatic alu_op_t branch_op(input logic [funct3_w-1:0] f3);
        case (f3)
            f3_beq:  branch_op = alu_eq;
            f3_bne:  branch_op = alu_ne;
            f3_blt:  branch_op = alu_lt;
            f3_bge:  branch_op = alu_ge;
            f3_bltu: branch_op = alu_ltu;
            default: branch_op = alu_geu;
        endcase
    endfunction

    assign instr_eff = is_legal(instr_i) ? instr_i : nop_instr;
    assign opcode    = opcode_t'(instr_eff[opcode_w-1:0]);
    assign funct3    = instr_eff[14:12];
    assign funct7    = instr_eff[31:25];
    assign rd        = instr_eff[11:7];

    always_comb begin
        ctrl_o    = '0;   // add rs1 rs2, sequential pc, no side effects
        writes_rd = 1'b0;
        case (opcode)
            opc_op: begin
                ctrl_o.alu_op = arith_op(funct3, funct7 == funct7_alt);
                writes_rd     = 1'b1;
            end
            opc_op_imm: begin   // imm bit 30 only means sra here
                ctrl_o.alu_op   = arith_op(funct3, funct3 == f3_sr && funct7 == funct7_alt);
                ctrl_o.op_b_sel = op_b_imm_i;
                writes_rd       = 1'b1;
            end
            opc_lui, opc_auipc: begin
                ctrl_o.op_a_sel = (opcode == opc_lui) ? op_a_zero : op_a_pc;
                ctrl_o.op_b_sel = op_b_imm_u;
                writes_rd       = 1'b1;
            end
            opc_branch: begin
                ctrl_o.alu_op = branch_op(funct3);
                ctrl_o.pc_sel = pc_sel_branch;
            end
            opc_jal, opc_jalr: begin   // alu makes the link pc + 4
                ctrl_o.op_a_sel = op_a_pc;
                ctrl_o.op_b_sel = op_b_four;
                ctrl_o.pc_sel   = (opcode == opc_jal) ? pc_sel_jal : pc_sel_jalr;
                writes_rd       = 1'b1;
            end
            opc_load: begin
                ctrl_o.op_b_sel    = op_b_imm_i;
                ctrl_o.mem_req     = 1'b1;
                ctrl_o.wb_from_mem = 1'b1;
                writes_rd          = 1'b1;
            end
            opc_store: begin
                ctrl_o.op_b_sel = op_b_imm_s;
                ctrl_o.mem_req  = 1'b1;
                ctrl_o.mem_we   = 1'b1;
            end
            default: ;
        endcase
        ctrl_o.rf_we = writes_rd && (rd != '0);   // x0 target never strobes, so nop writes nothing
    end

    // immediates straight from the fetched word
    assign imm_o.imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_o.imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_o.imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                          instr_i[11:8], 1'b0};
    assign imm_o.imm_u = {instr_i[31:12], 12'b0};
    assign imm_o.imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                          instr_i[30:21], 1'b0};

    mem_we_needs_req_a: assert final (!ctrl_o.mem_we || ctrl_o.mem_req);

endmodule

// File: verilog/core_isa_pkg.sv
package core_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////
    localparam int xlen       = 32;   // data and address width
    localparam int reg_addr_w = 5;    // 32 gprs
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes, rv32i subset only
    typedef enum logic [opcode_w-1:0] {
        opc_op     = 7'b0110011,   // reg-reg
        opc_op_imm = 7'b0010011,   // reg-imm
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    // branch conditions
    localparam logic [funct3_w-1:0] f3_beq  = 3'b000;
    localparam logic [funct3_w-1:0] f3_bne  = 3'b001;
    localparam logic [funct3_w-1:0] f3_blt  = 3'b100;
    localparam logic [funct3_w-1:0] f3_bge  = 3'b101;
    localparam logic [funct3_w-1:0] f3_bltu = 3'b110;
    localparam logic [funct3_w-1:0] f3_bgeu = 3'b111;

    // alu functions, shared by op and op_imm
    localparam logic [funct3_w-1:0] f3_add  = 3'b000;   // add / sub
    localparam logic [funct3_w-1:0] f3_sll  = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt  = 3'b010;
    localparam logic [funct3_w-1:0] f3_sltu = 3'b011;
    localparam logic [funct3_w-1:0] f3_xor  = 3'b100;
    localparam logic [funct3_w-1:0] f3_sr   = 3'b101;   // srl / sra
    localparam logic [funct3_w-1:0] f3_or   = 3'b110;
    localparam logic [funct3_w-1:0] f3_and  = 3'b111;
    localparam logic [funct3_w-1:0] f3_word = 3'b010;   // lw / sw

    localparam logic [funct7_w-1:0] funct7_alt = 7'b0100000;   // sub, sra

    // all immediate formats of one instruction, sign extended
    typedef struct packed {
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_u;
        word_t imm_j;
    } imm_t;

    localparam word_t nop_instr = 32'h0000_0013;   // addi x0, x0, 0

endpackage

// File: verilog/core_reg_file.sv
module core_reg_file (
    input  logic                    CLK,
    input  logic                    RESET,
    input  core_isa_pkg::reg_addr_t rs1_addr_i,
    input  core_isa_pkg::reg_addr_t rs2_addr_i,
    input  core_isa_pkg::reg_addr_t rd_addr_i,
    input  core_isa_pkg::word_t     rd_data_i,
    input  logic                    rd_we_i,
    output core_isa_pkg::word_t     rs1_data_o,
    output core_isa_pkg::word_t     rs2_data_o
);
    import core_isa_pkg::*;

    word_t regs [0:(1 << reg_addr_w) - 1];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && rd_addr_i != '0) begin   // x0 writes dropped
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // async read, new value seen next cycle
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // x0 only stays zero because reset clears it and writes skip it
    x0_reads_zero_a: assert property (@(posedge CLK) disable iff (RESET)
        rs1_addr_i == '0 |-> rs1_data_o == '0);

endmodule

// File: verilog/core_top.sv
module core_top (
    input  logic                     CLK,
    input  logic                     RESET,
    output core_isa_pkg::word_t      pc_o,
    input  core_isa_pkg::word_t      instr_i,
    output core_ctrl_pkg::dmem_req_t dmem_o,
    input  core_isa_pkg::word_t      dmem_rdata_i
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t pc_q;
    word_t npc;
    word_t pc_plus_step;
    word_t jalr_sum;
    ctrl_t ctrl;
    imm_t  imm;
    word_t rs1_data;
    word_t rs2_data;
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    logic  alu_flag;
    word_t rd_data;

    //////////////////////////////////////////////////////////////////////
    // decode, register file, alu
    //////////////////////////////////////////////////////////////////////
    core_decoder u_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl),
        .imm_o   (imm)
    );

    core_reg_file u_reg_file (
        .CLK        (CLK),
        .RESET      (RESET),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rd_addr_i  (instr_i[11:7]),
        .rd_data_i  (rd_data),
        .rd_we_i    (ctrl.rf_we),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    always_comb begin
        op_a = '0;   // op_a_zero
        case (ctrl.op_a_sel)
            op_a_rs1: op_a = rs1_data;
            op_a_pc:  op_a = pc_q;
            default:  ;
        endcase
        op_b = pc_step;   // op_b_four
        case (ctrl.op_b_sel)
            op_b_rs2:   op_b = rs2_data;
            op_b_imm_i: op_b = imm.imm_i;
            op_b_imm_u: op_b = imm.imm_u;
            op_b_imm_s: op_b = imm.imm_s;
            default:    ;
        endcase
    end

    core_alu u_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (ctrl.alu_op),
        .result_o (alu_result),
        .flag_o   (alu_flag)
    );

    assign rd_data = ctrl.wb_from_mem ? dmem_rdata_i : alu_result;

    // data port, alu sum is the address
    assign dmem_o.req   = ctrl.mem_req && !RESET;   // idle in reset
    assign dmem_o.we    = ctrl.mem_we && !RESET;
    assign dmem_o.addr  = alu_result;
    assign dmem_o.wdata = rs2_data;

    //////////////////////////////////////////////////////////////////////
    // program counter
    //////////////////////////////////////////////////////////////////////
    assign pc_plus_step = pc_q + pc_step;
    assign jalr_sum     = rs1_data + imm.imm_i;   // alu is busy with the link

    always_comb begin
        npc = pc_plus_step;
        case (ctrl.pc_sel)
            pc_sel_branch: npc = alu_flag ? pc_q + imm.imm_b : pc_plus_step;
            pc_sel_jal:    npc = pc_q + imm.imm_j;
            pc_sel_jalr:   npc = {jalr_sum[xlen-1:1], 1'b0};   // bit 0 cleared
            default:       ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= npc;
        end
    end

    assign pc_o = pc_q;

    pc_aligned_a: assert property (@(posedge CLK) disable iff (RESET)
        pc_o[1:0] == 2'b00);
    we_has_req_a: assert property (@(posedge CLK) disable iff (RESET)
        $rose(dmem_o.we) |-> dmem_o.req);

endmodule
